// File: files.f
+incdir+bench
hw/rv_pkg.sv
hw/fetch_unit.sv
hw/pipe_stage.sv
hw/reg_file.sv
hw/decoder.sv
hw/execute_unit.sv
hw/rv_core.sv
bench/tb_rv_core.sv

// File: bench/tb_programs.svh
// ----------------------------
// instruction encoders and the test
// programs with their expected stores
// ----------------------------
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, rv_pkg::OPC_OP};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_pkg::OPC_STORE};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::OPC_BRANCH};
endfunction

function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, rv_pkg::OPC_LUI};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::OPC_JAL};
endfunction

function automatic logic [31:0] sx(input logic [11:0] v);
    return {{20{v[11]}}, v};
endfunction

task automatic clear_prog();
    for (int i = 0; i < 256; i++) begin
        imem[i] = rv_pkg::NOP_INST;
    end
    pc_idx  = 0;
    st_addr = 32'h100;
    exp_addr.delete();
    exp_data.delete();
endtask

task automatic put(input logic [31:0] word);
    imem[pc_idx] = word;
    pc_idx++;
endtask

// store rs2 to the next log address and expect data there
task automatic sw_check(input logic [4:0] rs2, input logic [31:0] data);
    put(enc_s(st_addr[11:0], rs2, 5'd0));
    exp_addr.push_back(st_addr);
    exp_data.push_back(data);
    st_addr += 4;
endtask

task automatic put_bad();
    put(enc_s(12'h3F0, 5'd8, 5'd0));    // wrong path, must never complete
endtask

task automatic alu_r(input logic [6:0] f7, input logic [2:0] f3, input logic [31:0] exp);
    put(enc_r(f7, 5'd2, 5'd1, f3, 5'd4));
    sw_check(5'd4, exp);
endtask

task automatic alu_i(input logic [4:0] rs1, input logic [11:0] imm, input logic [2:0] f3,
                     input logic [31:0] exp);
    put(enc_i(imm, rs1, f3, 5'd4, rv_pkg::OPC_OP_IMM));
    sw_check(5'd4, exp);
endtask

task automatic load_alu_prog();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    a = 32'hFFFF_FFF8;
    b = 32'd11;
    c = 32'h8000_0000;
    clear_prog();
    put(enc_i(12'hFF8, 5'd0, 3'b000, 5'd1, rv_pkg::OPC_OP_IMM));
    put(enc_i(12'h00B, 5'd0, 3'b000, 5'd2, rv_pkg::OPC_OP_IMM));
    put(enc_u(20'h80000, 5'd3));
    alu_r(7'h00, 3'b000, a + b);
    alu_r(7'h20, 3'b000, a - b);
    alu_r(7'h00, 3'b111, a & b);
    alu_r(7'h00, 3'b110, a | b);
    alu_r(7'h00, 3'b100, a ^ b);
    alu_r(7'h00, 3'b001, a << b[4:0]);
    alu_r(7'h00, 3'b101, a >> b[4:0]);
    alu_r(7'h20, 3'b101, $signed(a) >>> b[4:0]);
    alu_r(7'h00, 3'b010, {31'b0, $signed(a) < $signed(b)});
    alu_r(7'h00, 3'b011, {31'b0, a < b});
    alu_i(5'd1, 12'h064, 3'b000, a + sx(12'h064));
    alu_i(5'd1, 12'h0F0, 3'b111, a & sx(12'h0F0));
    alu_i(5'd1, 12'h505, 3'b110, a | sx(12'h505));
    alu_i(5'd1, 12'hFFF, 3'b100, a ^ sx(12'hFFF));
    alu_i(5'd1, 12'hFF9, 3'b010, {31'b0, $signed(a) < $signed(sx(12'hFF9))});
    alu_i(5'd2, 12'hFF9, 3'b011, {31'b0, b < sx(12'hFF9)});
    alu_i(5'd2, 12'hFFF, 3'b010, {31'b0, $signed(b) < $signed(sx(12'hFFF))});
    alu_i(5'd1, 12'h004, 3'b001, a << 4);
    alu_i(5'd1, 12'h01C, 3'b101, a >> 28);
    alu_i(5'd3, 12'h404, 3'b101, $signed(c) >>> 4);  // sign fills from bit 31
    sw_check(5'd3, c);
    put(enc_j(21'd0, 5'd0));
endtask

task automatic load_dep_prog();
    clear_prog();
    put(enc_i(12'd1, 5'd0, 3'b000, 5'd5, rv_pkg::OPC_OP_IMM));
    put(enc_i(12'd2, 5'd5, 3'b000, 5'd5, rv_pkg::OPC_OP_IMM));
    put(enc_r(7'h00, 5'd5, 5'd5, 3'b000, 5'd5));
    put(enc_i(12'd1, 5'd5, 3'b001, 5'd5, rv_pkg::OPC_OP_IMM));
    sw_check(5'd5, ((32'd1 + 32'd2) * 2) << 1);
    put(enc_i(12'd7, 5'd0, 3'b000, 5'd6, rv_pkg::OPC_OP_IMM));
    sw_check(5'd6, 32'd7);                  // store data straight from bypass
    put(enc_i(12'd55, 5'd0, 3'b000, 5'd0, rv_pkg::OPC_OP_IMM));
    sw_check(5'd0, 32'd0);
    put(enc_r(7'h00, 5'd0, 5'd6, 3'b000, 5'd7));
    sw_check(5'd7, 32'd7);
    put(enc_j(21'd0, 5'd0));
endtask

task automatic load_ctrl_prog();
    logic [31:0] link;
    clear_prog();
    put(enc_i(12'd5, 5'd0, 3'b000, 5'd8, rv_pkg::OPC_OP_IMM));
    put(enc_i(12'd5, 5'd0, 3'b000, 5'd9, rv_pkg::OPC_OP_IMM));
    put(enc_b(13'd12, 5'd9, 5'd8, 3'b000));     // beq taken
    put_bad();
    put_bad();
    put(enc_i(12'd1, 5'd0, 3'b000, 5'd10, rv_pkg::OPC_OP_IMM));
    sw_check(5'd10, 32'd1);
    put(enc_b(13'd12, 5'd9, 5'd8, 3'b001));     // bne not taken
    sw_check(5'd8, 32'd5);
    put(enc_b(13'd12, 5'd0, 5'd8, 3'b001));     // bne taken
    put_bad();
    put_bad();
    link = pc_idx * 4 + 4;
    put(enc_j(21'd12, 5'd11));
    put_bad();
    put_bad();
    sw_check(5'd11, link);
    put(enc_j(21'd0, 5'd0));
endtask

task automatic load_mem_prog();
    clear_prog();
    st_addr = 32'h200;
    put(enc_u(20'h12345, 5'd12));
    put(enc_i(12'h678, 5'd12, 3'b000, 5'd12, rv_pkg::OPC_OP_IMM));
    sw_check(5'd12, 32'h1234_5678);
    put(enc_i(12'h200, 5'd0, 3'b010, 5'd13, rv_pkg::OPC_LOAD));
    sw_check(5'd13, 32'h1234_5678);
    put(enc_i(12'h200, 5'd0, 3'b010, 5'd14, rv_pkg::OPC_LOAD));
    put(enc_i(12'd1, 5'd14, 3'b000, 5'd15, rv_pkg::OPC_OP_IMM));
    sw_check(5'd15, 32'h1234_5679);
    put(enc_i(12'h300, 5'd0, 3'b010, 5'd16, rv_pkg::OPC_LOAD));
    sw_check(5'd16, fill_word(32'h300 >> 2));
    put(enc_j(21'd0, 5'd0));
endtask

`endif

// File: bench/tb_rv_core.sv
// ----------------------------
// clock and reset, memory model with
// random hold and store log checks
// ----------------------------
module tb_rv_core;

    logic        clk;
    logic        arst_n;
    logic        hold;
    logic        hold_en;
    logic [31:0] rng;
    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    int          pc_idx;
    logic [31:0] st_addr;
    int          store_cnt;
    int          errors;
    int          tests_run;
    int          tests_failed;

    logic [31:0] pc_addr;
    logic [31:0] inst_data;
    logic [31:0] ex_addr;
    logic [31:0] ex_wdata;
    logic [31:0] ex_rdata;
    logic        ex_req;
    logic        ex_we;

    // state of a request seen under hold
    logic        held_req;
    logic [31:0] held_addr;
    logic [31:0] held_wdata;
    logic        held_we;

    function automatic logic [31:0] fill_word(input int idx);
        return 32'hC3C3_0000 ^ (idx << 2) ^ (idx << 20);
    endfunction

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    `include "tb_programs.svh"

    assign inst_data = imem[pc_addr[9:2]];    // combinational fetch
    assign ex_rdata  = dmem[ex_addr[9:2]];

    rv_core dut (
        .clk             (clk),
        .arst_n_i        (arst_n),
        .rib_pc_addr_o   (pc_addr),
        .rib_pc_data_i   (inst_data),
        .rib_ex_addr_o   (ex_addr),
        .rib_ex_data_o   (ex_wdata),
        .rib_ex_req_o    (ex_req),
        .rib_ex_we_o     (ex_we),
        .rib_ex_data_i   (ex_rdata),
        .rib_hold_flag_i (hold)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(negedge clk) begin
        if (hold_en) begin
            rng = xorshift(rng);
            hold <= (rng[1:0] == 2'b00);    // roughly one cycle in four
        end else begin
            hold <= 1'b0;
        end
    end

    always @(posedge clk) begin
        if (!arst_n) begin
            held_req <= 1'b0;
        end else begin
            if (held_req) begin
                assert (ex_req) else begin
                    $display("held request dropped before it completed");
                    errors++;
                end
                assert (ex_addr == held_addr) else begin
                    $display("FAIL rib_ex_addr_o expected %h got %h", held_addr, ex_addr);
                    errors++;
                end
                assert (ex_wdata == held_wdata) else begin
                    $display("FAIL rib_ex_data_o expected %h got %h", held_wdata, ex_wdata);
                    errors++;
                end
                assert (ex_we == held_we) else begin
                    $display("FAIL rib_ex_we_o expected %h got %h", held_we, ex_we);
                    errors++;
                end
            end
            held_req   <= ex_req && hold;
            held_addr  <= ex_addr;
            held_wdata <= ex_wdata;
            held_we    <= ex_we;
            if (ex_req && !hold && ex_we) begin
                assert (store_cnt < exp_addr.size()) else begin
                    $display("unexpected extra store to address %h", ex_addr);
                    errors++;
                end
                if (store_cnt < exp_addr.size()) begin
                    assert (ex_addr == exp_addr[store_cnt]) else begin
                        $display("FAIL rib_ex_addr_o expected %h got %h",
                                 exp_addr[store_cnt], ex_addr);
                        errors++;
                    end
                    assert (ex_wdata == exp_data[store_cnt]) else begin
                        $display("FAIL rib_ex_data_o expected %h got %h",
                                 exp_data[store_cnt], ex_wdata);
                        errors++;
                    end
                end
                dmem[ex_addr[9:2]] <= ex_wdata;
                store_cnt++;
            end
        end
    end

    // 4 reset cycles with the bus idle and pc at its reset value
    task automatic reset_core();
        arst_n    = 1'b0;
        hold_en  <= 1'b0;
        store_cnt = 0;
        for (int i = 0; i < 256; i++) begin
            dmem[i] = fill_word(i);
        end
        @(posedge clk);
        for (int c = 0; c < 4; c++) begin
            @(negedge clk);
            if (c == 3) arst_n = 1'b1;  // last check right after release
            assert (ex_req == 1'b0) else begin
                $display("FAIL rib_ex_req_o expected %h got %h", 1'b0, ex_req);
                errors++;
            end
            assert (pc_addr == rv_pkg::RESET_PC) else begin
                $display("FAIL rib_pc_addr_o expected %h got %h", rv_pkg::RESET_PC, pc_addr);
                errors++;
            end
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - errs_before);
        end
    endtask

    task automatic run_prog(input string name);
        int errs_before;
        int cycles;
        errs_before = errors;
        reset_core();
        hold_en <= 1'b1;
        cycles   = 0;
        while (store_cnt < exp_addr.size() && cycles < 2000) begin
            @(negedge clk);
            cycles++;
        end
        if (store_cnt < exp_addr.size()) begin
            $display("timeout in %s, only %0d of %0d stores seen", name, store_cnt,
                     exp_addr.size());
            errors++;
        end
        repeat (40) @(negedge clk);     // catches late stray stores
        finish_test(name, errs_before);
    endtask

    initial begin
        int errs_before;
        arst_n       = 1'b0;
        hold         = 1'b0;
        hold_en      = 1'b0;
        rng          = 32'h04640322;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        clear_prog();
        errs_before = errors;
        reset_core();
        finish_test("reset", errs_before);
        load_alu_prog();
        run_prog("alu");
        load_dep_prog();
        run_prog("dependencies");
        load_ctrl_prog();
        run_prog("control");
        load_mem_prog();
        run_prog("memory");
        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: hw/rv_core.sv
// ----------------------------
// rv32i core top: fetch, if/id,
// decode + regs, id/ex, execute
// ----------------------------
module rv_core (
    input  logic                    clk,
    input  logic                    arst_n_i,

    output logic [rv_pkg::XLEN-1:0] rib_pc_addr_o,     // fetch address
    input  logic [31:0]             rib_pc_data_i,     // instruction, same cycle

    output logic [rv_pkg::XLEN-1:0] rib_ex_addr_o,     // load/store address
    output logic [rv_pkg::XLEN-1:0] rib_ex_data_o,     // store data
    output logic                    rib_ex_req_o,
    output logic                    rib_ex_we_o,
    input  logic [rv_pkg::XLEN-1:0] rib_ex_data_i,     // load data
    input  logic                    rib_hold_flag_i    // bus stall, freezes core
);

    // fetch side
    logic [rv_pkg::XLEN-1:0]       pc;
    rv_pkg::fetch_pkt_t            if_pkt;
    rv_pkg::fetch_pkt_t            id_pkt;

    // decode side
    logic [rv_pkg::REG_ADDR_W-1:0] id_raddr1;
    logic [rv_pkg::REG_ADDR_W-1:0] id_raddr2;
    logic [rv_pkg::XLEN-1:0]       regs_rdata1;
    logic [rv_pkg::XLEN-1:0]       regs_rdata2;
    rv_pkg::exec_pkt_t             id_exec;
    rv_pkg::exec_pkt_t             ex_pkt;

    // execute side
    logic                          ex_reg_we;
    logic [rv_pkg::REG_ADDR_W-1:0] ex_reg_waddr;
    logic [rv_pkg::XLEN-1:0]       ex_reg_wdata;
    logic                          ex_jump;
    logic [rv_pkg::XLEN-1:0]       ex_jump_addr;

    assign rib_pc_addr_o = pc;
    assign if_pkt        = '{inst: rib_pc_data_i, pc: pc};

    fetch_unit u_fetch (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .hold_i      (rib_hold_flag_i),
        .jump_i      (ex_jump),
        .jump_addr_i (ex_jump_addr),
        .pc_o        (pc)
    );

    pipe_stage #(
        .payload_t (rv_pkg::fetch_pkt_t),
        .BUBBLE    (rv_pkg::FETCH_BUBBLE)
    ) u_if_id (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .hold_i   (rib_hold_flag_i),
        .flush_i  (ex_jump),
        .data_i   (if_pkt),
        .data_o   (id_pkt)
    );

    reg_file u_regs (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .we_i     (ex_reg_we),
        .waddr_i  (ex_reg_waddr),
        .wdata_i  (ex_reg_wdata),
        .raddr1_i (id_raddr1),
        .raddr2_i (id_raddr2),
        .rdata1_o (regs_rdata1),
        .rdata2_o (regs_rdata2)
    );

    decoder u_dec (
        .inst_i   (id_pkt),
        .rdata1_i (regs_rdata1),
        .rdata2_i (regs_rdata2),
        .raddr1_o (id_raddr1),
        .raddr2_o (id_raddr2),
        .exec_o   (id_exec)
    );

    pipe_stage #(
        .payload_t (rv_pkg::exec_pkt_t),
        .BUBBLE    (rv_pkg::EXEC_BUBBLE)
    ) u_id_ex (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .hold_i   (rib_hold_flag_i),
        .flush_i  (ex_jump),
        .data_i   (id_exec),
        .data_o   (ex_pkt)
    );

    execute_unit u_ex (
        .exec_i      (ex_pkt),
        .mem_rdata_i (rib_ex_data_i),
        .hold_i      (rib_hold_flag_i),
        .mem_addr_o  (rib_ex_addr_o),
        .mem_wdata_o (rib_ex_data_o),
        .mem_req_o   (rib_ex_req_o),
        .mem_we_o    (rib_ex_we_o),
        .reg_we_o    (ex_reg_we),
        .reg_waddr_o (ex_reg_waddr),
        .reg_wdata_o (ex_reg_wdata),
        .jump_o      (ex_jump),
        .jump_addr_o (ex_jump_addr)
    );

endmodule

// File: hw/execute_unit.sv
// ----------------------------
// ALU, branch resolution, data bus
// and register writeback
// ----------------------------
module execute_unit (
    input  rv_pkg::exec_pkt_t             exec_i,
    input  logic [rv_pkg::XLEN-1:0]       mem_rdata_i,   // valid in completing cycle
    input  logic                          hold_i,
    output logic [rv_pkg::XLEN-1:0]       mem_addr_o,
    output logic [rv_pkg::XLEN-1:0]       mem_wdata_o,
    output logic                          mem_req_o,
    output logic                          mem_we_o,
    output logic                          reg_we_o,
    output logic [rv_pkg::REG_ADDR_W-1:0] reg_waddr_o,
    output logic [rv_pkg::XLEN-1:0]       reg_wdata_o,
    output logic                          jump_o,
    output logic [rv_pkg::XLEN-1:0]       jump_addr_o
);

    logic [rv_pkg::XLEN-1:0] op1;
    logic [rv_pkg::XLEN-1:0] op2;
    logic [rv_pkg::XLEN-1:0] sum;
    logic [rv_pkg::XLEN-1:0] alu_res;
    logic [4:0]              shamt;
    logic                    op_eq;
    logic                    taken;

    assign op1   = exec_i.op1;
    assign op2   = exec_i.op2;
    assign sum   = op1 + op2;
    assign shamt = op2[4:0];

    always_comb begin
        case (exec_i.alu_op)
            rv_pkg::ALU_ADD:  alu_res = sum;
            rv_pkg::ALU_SUB:  alu_res = op1 - op2;
            rv_pkg::ALU_AND:  alu_res = op1 & op2;
            rv_pkg::ALU_OR:   alu_res = op1 | op2;
            rv_pkg::ALU_XOR:  alu_res = op1 ^ op2;
            rv_pkg::ALU_SLL:  alu_res = op1 << shamt;
            rv_pkg::ALU_SRL:  alu_res = op1 >> shamt;
            rv_pkg::ALU_SRA:  alu_res = $signed(op1) >>> shamt;
            rv_pkg::ALU_SLT:  alu_res = {31'b0, $signed(op1) < $signed(op2)};
            rv_pkg::ALU_SLTU: alu_res = {31'b0, op1 < op2};
            rv_pkg::ALU_PASS: alu_res = op2;
            default:          alu_res = sum;
        endcase
    end

    // branch condition
    assign op_eq = (op1 == op2);
    assign taken = exec_i.is_jal || (exec_i.is_branch && (op_eq ^ exec_i.branch_ne));

    // no redirect while the bus stalls us, the stage is replayed
    assign jump_o      = taken && !hold_i;
    assign jump_addr_o = exec_i.jump_base + exec_i.jump_off;

    // data bus, stable under hold since the id/ex stage is frozen
    assign mem_addr_o  = sum;
    assign mem_wdata_o = exec_i.store_data;
    assign mem_req_o   = exec_i.is_load || exec_i.is_store;
    assign mem_we_o    = exec_i.is_store;

    // writeback
    assign reg_we_o    = exec_i.reg_we && !hold_i;
    assign reg_waddr_o = exec_i.rd;
    assign reg_wdata_o = exec_i.is_load ? mem_rdata_i : alu_res;

endmodule

// File: hw/decoder.sv
// ----------------------------
// instruction decode, immediates
// and operand selection
// ----------------------------
module decoder (
    input  rv_pkg::fetch_pkt_t            inst_i,
    input  logic [rv_pkg::XLEN-1:0]       rdata1_i,
    input  logic [rv_pkg::XLEN-1:0]       rdata2_i,
    output logic [rv_pkg::REG_ADDR_W-1:0] raddr1_o,
    output logic [rv_pkg::REG_ADDR_W-1:0] raddr2_o,
    output rv_pkg::exec_pkt_t             exec_o
);

    localparam logic [rv_pkg::XLEN-1:0] LINK_OFS = 4;

    logic [31:0]                   inst;
    logic [6:0]                    opcode;
    logic [2:0]                    funct3;
    logic [6:0]                    funct7;
    logic [rv_pkg::XLEN-1:0]       imm_i;
    logic [rv_pkg::XLEN-1:0]       imm_s;
    logic [rv_pkg::XLEN-1:0]       imm_b;
    logic [rv_pkg::XLEN-1:0]       imm_u;
    logic [rv_pkg::XLEN-1:0]       imm_j;
    logic                          is_reg_op;
    logic                          alt;        // funct7[5], sub or sra
    logic                          f7_legal;
    rv_pkg::alu_op_e               alu_sel;

    assign inst   = inst_i.inst;
    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign raddr1_o = inst[19:15];
    assign raddr2_o = inst[24:20];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    assign is_reg_op = (opcode == rv_pkg::OPC_OP);
    assign alt       = funct7[5];

    // shared op map for OP and OP-IMM
    always_comb begin
        case (funct3)
            3'b000:  alu_sel = (is_reg_op && alt) ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            3'b001:  alu_sel = rv_pkg::ALU_SLL;
            3'b010:  alu_sel = rv_pkg::ALU_SLT;
            3'b011:  alu_sel = rv_pkg::ALU_SLTU;
            3'b100:  alu_sel = rv_pkg::ALU_XOR;
            3'b101:  alu_sel = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            3'b110:  alu_sel = rv_pkg::ALU_OR;
            default: alu_sel = rv_pkg::ALU_AND;
        endcase
    end

    // funct7 check, anything else (mul etc) falls out as a no-op
    always_comb begin
        if (is_reg_op) begin
            f7_legal = (funct7 == 7'h00) ||
                       (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101));
        end else if (funct3 == 3'b001) begin
            f7_legal = (funct7 == 7'h00);
        end else if (funct3 == 3'b101) begin
            f7_legal = (funct7 == 7'h00) || (funct7 == 7'h20);
        end else begin
            f7_legal = 1'b1;    // imm bits, not funct7
        end
    end

    always_comb begin
        exec_o = rv_pkg::EXEC_BUBBLE;
        case (opcode)
            rv_pkg::OPC_OP, rv_pkg::OPC_OP_IMM: begin
                if (f7_legal) begin
                    exec_o.alu_op = alu_sel;
                    exec_o.op1    = rdata1_i;
                    exec_o.op2    = is_reg_op ? rdata2_i : imm_i;
                    exec_o.rd     = inst[11:7];
                    exec_o.reg_we = 1'b1;
                end
            end
            rv_pkg::OPC_LUI: begin
                exec_o.alu_op = rv_pkg::ALU_PASS;   // op1 stays zero
                exec_o.op2    = imm_u;
                exec_o.rd     = inst[11:7];
                exec_o.reg_we = 1'b1;
            end
            rv_pkg::OPC_JAL: begin
                exec_o.op1       = inst_i.pc;       // link = pc + 4
                exec_o.op2       = LINK_OFS;
                exec_o.jump_base = inst_i.pc;
                exec_o.jump_off  = imm_j;
                exec_o.rd        = inst[11:7];
                exec_o.reg_we    = 1'b1;
                exec_o.is_jal    = 1'b1;
            end
            rv_pkg::OPC_BRANCH: begin
                if (funct3[2:1] == 2'b00) begin      // beq / bne only
                    exec_o.op1       = rdata1_i;
                    exec_o.op2       = rdata2_i;
                    exec_o.jump_base = inst_i.pc;
                    exec_o.jump_off  = imm_b;
                    exec_o.is_branch = 1'b1;
                    exec_o.branch_ne = funct3[0];
                end
            end
            rv_pkg::OPC_LOAD: begin
                if (funct3 == 3'b010) begin         // lw
                    exec_o.op1     = rdata1_i;
                    exec_o.op2     = imm_i;
                    exec_o.rd      = inst[11:7];
                    exec_o.reg_we  = 1'b1;
                    exec_o.is_load = 1'b1;
                end
            end
            rv_pkg::OPC_STORE: begin
                if (funct3 == 3'b010) begin         // sw
                    exec_o.op1        = rdata1_i;
                    exec_o.op2        = imm_s;
                    exec_o.store_data = rdata2_i;
                    exec_o.is_store   = 1'b1;
                end
            end
            default: ;
        endcase
    end

endmodule

// File: hw/reg_file.sv
// ----------------------------
// 32 x XLEN register file, x0 reads zero
// ----------------------------
module reg_file (
    input  logic                          clk,
    input  logic                          arst_n_i,
    input  logic                          we_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] waddr_i,
    input  logic [rv_pkg::XLEN-1:0]       wdata_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] raddr1_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] raddr2_i,
    output logic [rv_pkg::XLEN-1:0]       rdata1_o,
    output logic [rv_pkg::XLEN-1:0]       rdata2_o
);

    logic [rv_pkg::XLEN-1:0] regs [32];
    logic                    wr_live;   // real write this cycle

    assign wr_live = we_i && (waddr_i != '0);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // write-to-read bypass, lets decode see the value execute is writing
    assign rdata1_o = (raddr1_i == '0) ? '0 :
                      (wr_live && waddr_i == raddr1_i) ? wdata_i : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 :
                      (wr_live && waddr_i == raddr2_i) ? wdata_i : regs[raddr2_i];

endmodule

// File: hw/pipe_stage.sv
// ----------------------------
// pipeline register with hold and flush
// ----------------------------
module pipe_stage #(
    parameter type      payload_t = logic [31:0],
    parameter payload_t BUBBLE    = '0
) (
    input  logic     clk,
    input  logic     arst_n_i,
    input  logic     hold_i,
    input  logic     flush_i,
    input  payload_t data_i,
    output payload_t data_o
);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            data_o <= BUBBLE;
        end else if (flush_i) begin
            data_o <= BUBBLE;       // squash wrong-path instruction
        end else if (!hold_i) begin
            data_o <= data_i;
        end
    end

endmodule

// File: hw/fetch_unit.sv
// ----------------------------
// program counter: reset, hold
// and jump redirect
// ----------------------------
module fetch_unit (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  logic                    hold_i,        // bus stall
    input  logic                    jump_i,        // taken branch or jal
    input  logic [rv_pkg::XLEN-1:0] jump_addr_i,
    output logic [rv_pkg::XLEN-1:0] pc_o
);

    localparam logic [rv_pkg::XLEN-1:0] INST_BYTES = 4;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_o <= rv_pkg::RESET_PC;
        end else if (jump_i) begin
            // jump already masked by hold in execute
            pc_o <= jump_addr_i;
        end else if (!hold_i) begin
            pc_o <= pc_o + INST_BYTES;
        end
    end

endmodule

// File: hw/rv_pkg.sv
// ----------------------------
// core widths, opcodes, ALU op encoding
// and the two pipeline stage payloads
// ----------------------------
package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;
    localparam logic [31:0]     NOP_INST = 32'h0000_0013;   // addi x0, x0, 0

    // major opcodes, inst[6:0]
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_PASS            // op2 straight through, used by lui
    } alu_op_e;

    // if/id payload
    typedef struct packed {
        logic [31:0]     inst;
        logic [XLEN-1:0] pc;
    } fetch_pkt_t;

    // id/ex payload
    typedef struct packed {
        alu_op_e                alu_op;
        logic [XLEN-1:0]        op1;
        logic [XLEN-1:0]        op2;
        logic [XLEN-1:0]        jump_base;
        logic [XLEN-1:0]        jump_off;
        logic [XLEN-1:0]        store_data;
        logic [REG_ADDR_W-1:0]  rd;
        logic                   reg_we;
        logic                   is_load;
        logic                   is_store;
        logic                   is_branch;
        logic                   branch_ne;  // 0 beq, 1 bne
        logic                   is_jal;
    } exec_pkt_t;

    // contents of a flushed or reset stage
    localparam fetch_pkt_t FETCH_BUBBLE = '{
        inst: NOP_INST,
        pc:   RESET_PC
    };

    localparam exec_pkt_t EXEC_BUBBLE = '{
        alu_op:  ALU_ADD,
        default: '0
    };

endpackage
